// File: dac_core_pkg.sv
// shared sizes and register map for a single clock core; word addresses are 14 bits wide
`default_nettype none

package dac_core_pkg;

  // ****************************************
  // sizes
  // ****************************************

  localparam int NUM_CHANNELS     = 2;
  localparam int SAMPLE_W         = 16;
  localparam int SAMPLES_PER_BEAT = 4;
  localparam int ADDR_W           = 14;
  localparam int DATA_W           = 32;

  localparam logic [DATA_W-1:0] CORE_VERSION = 32'h0001_0061;

  // ****************************************
  // common registers
  // ****************************************

  localparam logic [ADDR_W-1:0] REG_VERSION = 14'h0000;
  localparam logic [ADDR_W-1:0] REG_SCRATCH = 14'h0001;
  localparam logic [ADDR_W-1:0] REG_CTRL    = 14'h0002;
  localparam logic [ADDR_W-1:0] REG_SYNC    = 14'h0003;
  localparam logic [ADDR_W-1:0] REG_STATUS  = 14'h0004;

  // ****************************************
  // channel registers
  // ****************************************

  localparam logic [ADDR_W-1:0] CHAN_BASE     = 14'h0100;
  localparam logic [ADDR_W-1:0] CHAN_STRIDE   = 14'h0010;
  localparam logic [ADDR_W-1:0] CHAN_SRC      = 14'h0000;
  localparam logic [ADDR_W-1:0] CHAN_PATTERN  = 14'h0001;
  localparam logic [ADDR_W-1:0] CHAN_ENABLE   = 14'h0002;
  // offsets at or above this are left to the bus merge
  localparam logic [ADDR_W-1:0] CHAN_NUM_REGS = 14'h0003;

  typedef enum logic [1:0] {
    SRC_DMA     = 2'd0,
    SRC_PATTERN = 2'd1,
    SRC_RAMP    = 2'd2,
    SRC_ZERO    = 2'd3
  } dac_src_t;

  // sample 0 sits in the low bits
  typedef struct packed {
    logic [SAMPLES_PER_BEAT-1:0][SAMPLE_W-1:0] sample;
  } dac_frame_t;

  typedef struct packed {
    logic              wreq;
    logic [ADDR_W-1:0] waddr;
    logic [DATA_W-1:0] wdata;
    logic              rreq;
    logic [ADDR_W-1:0] raddr;
  } up_req_t;

  typedef struct packed {
    logic              wack;
    logic              rack;
    logic [DATA_W-1:0] rdata;
  } up_rsp_t;

endpackage

`default_nettype wire

// File: dac_channel.sv
// one channel; a config write reaches the frame a cycle after the top ack and DMA cannot stall
`timescale 1ns/1ps
`default_nettype none

module dac_channel #(
  parameter int CHANNEL_ID = 0
) (
  input  wire                      dac_clk,
  input  wire                      up_rstn,
  input  wire dac_core_pkg::up_req_t    up_req,
  output dac_core_pkg::up_rsp_t         up_rsp,
  input  wire dac_core_pkg::dac_frame_t dma_data,
  input  wire                      dac_rst,
  input  wire                      dac_sync,
  input  wire                      dac_datafmt,
  output dac_core_pkg::dac_frame_t      dac_data,
  output logic                     dac_valid,
  output logic                     dac_enable
);

  localparam int ADDR_OFS = CHANNEL_ID * dac_core_pkg::CHAN_STRIDE;
  localparam logic [dac_core_pkg::ADDR_W-1:0] CHAN_ADDR =
    dac_core_pkg::CHAN_BASE + ADDR_OFS[dac_core_pkg::ADDR_W-1:0];

  logic [dac_core_pkg::ADDR_W-1:0]   wr_off;
  logic [dac_core_pkg::ADDR_W-1:0]   rd_off;
  logic                              wr_hit;
  logic                              rd_hit;
  logic [dac_core_pkg::DATA_W-1:0]   rd_data;
  dac_core_pkg::dac_src_t            up_src;
  dac_core_pkg::dac_src_t            dac_src;
  logic [dac_core_pkg::SAMPLE_W-1:0] up_pattern;
  logic [dac_core_pkg::SAMPLE_W-1:0] dac_pattern;
  logic                              up_enable;
  logic [dac_core_pkg::SAMPLE_W-1:0] ramp_q;
  logic [dac_core_pkg::SAMPLE_W-1:0] ramp_cur;
  dac_core_pkg::dac_frame_t          frame_next;

  // ****************************************
  // register access
  // ****************************************

  // addresses below the window wrap to a large offset and miss
  assign wr_off = up_req.waddr - CHAN_ADDR;
  assign rd_off = up_req.raddr - CHAN_ADDR;
  assign wr_hit = up_req.wreq && (wr_off < dac_core_pkg::CHAN_NUM_REGS);
  assign rd_hit = up_req.rreq && (rd_off < dac_core_pkg::CHAN_NUM_REGS);

  always_comb begin
    rd_data = '0;
    case (rd_off)
      dac_core_pkg::CHAN_SRC:     rd_data[1:0] = up_src;
      dac_core_pkg::CHAN_PATTERN: rd_data[dac_core_pkg::SAMPLE_W-1:0] = up_pattern;
      dac_core_pkg::CHAN_ENABLE:  rd_data[0] = up_enable;
      default:                    rd_data = '0;
    endcase
  end

  always_ff @(posedge dac_clk) begin
    if (!up_rstn) begin
      up_rsp     <= '0;
      up_src     <= dac_core_pkg::SRC_DMA;
      up_pattern <= '0;
      up_enable  <= 1'b0;
    end else begin
      up_rsp.wack  <= wr_hit;
      up_rsp.rack  <= rd_hit;
      up_rsp.rdata <= rd_hit ? rd_data : '0;
      if (wr_hit) begin
        case (wr_off)
          dac_core_pkg::CHAN_SRC:     up_src <= dac_core_pkg::dac_src_t'(up_req.wdata[1:0]);
          dac_core_pkg::CHAN_PATTERN: up_pattern <= up_req.wdata[dac_core_pkg::SAMPLE_W-1:0];
          dac_core_pkg::CHAN_ENABLE:  up_enable <= up_req.wdata[0];
          default: ;
        endcase
      end
    end
  end

  // ****************************************
  // datapath
  // ****************************************

  // sync restarts the ramp in the same cycle it arrives
  assign ramp_cur  = (dac_rst || dac_sync) ? '0 : ramp_q;
  assign dac_valid = dac_enable && !dac_rst;

  always_comb begin : frame_calc
    logic [dac_core_pkg::SAMPLE_W-1:0] smp;
    frame_next = '0;
    for (int k = 0; k < dac_core_pkg::SAMPLES_PER_BEAT; k++) begin
      case (dac_src)
        dac_core_pkg::SRC_DMA:     smp = dma_data.sample[k];
        dac_core_pkg::SRC_PATTERN: smp = dac_pattern;
        dac_core_pkg::SRC_RAMP:    smp = ramp_cur + k[dac_core_pkg::SAMPLE_W-1:0];
        default:                   smp = '0;
      endcase
      // offset binary flips the sign bit
      if (dac_datafmt) begin
        smp[dac_core_pkg::SAMPLE_W-1] = ~smp[dac_core_pkg::SAMPLE_W-1];
      end
      frame_next.sample[k] = smp;
    end
    if (dac_rst || !dac_enable) begin
      frame_next = '0;
    end
  end

  // config copies add the stage between register write and datapath
  always_ff @(posedge dac_clk) begin
    if (!up_rstn) begin
      dac_src     <= dac_core_pkg::SRC_DMA;
      dac_pattern <= '0;
      dac_enable  <= 1'b0;
      ramp_q      <= '0;
      dac_data    <= '0;
    end else begin
      dac_src     <= up_src;
      dac_pattern <= up_pattern;
      dac_enable  <= up_enable;
      ramp_q      <= dac_rst ? '0 :
                     ramp_cur + dac_core_pkg::SAMPLES_PER_BEAT[dac_core_pkg::SAMPLE_W-1:0];
      dac_data    <= frame_next;
    end
  end

endmodule

`default_nettype wire

// File: dac_common_regs.sv
// core-wide registers on dac_clk; the converter reset stays asserted until software sets resetn
`timescale 1ns/1ps
`default_nettype none

module dac_common_regs (
  input  wire                   dac_clk,
  input  wire                   up_rstn,
  input  wire dac_core_pkg::up_req_t up_req,
  output dac_core_pkg::up_rsp_t      up_rsp,
  input  wire                   dac_dunf,
  input  wire                   dac_dovf,
  output logic                  dac_rst,
  output logic                  dac_sync,
  output logic                  dac_datafmt
);

  logic [dac_core_pkg::DATA_W-1:0] up_scratch;
  logic                            up_resetn;
  logic                            up_datafmt;
  // bit 0 underflow, bit 1 overflow
  logic [1:0]                      up_status;
  logic [1:0]                      status_clr;
  logic                            wr_hit;
  logic                            rd_hit;
  logic [dac_core_pkg::DATA_W-1:0] rd_data;

  // ****************************************
  // address decode
  // ****************************************

  always_comb begin
    wr_hit = 1'b0;
    case (up_req.waddr)
      dac_core_pkg::REG_VERSION,
      dac_core_pkg::REG_SCRATCH,
      dac_core_pkg::REG_CTRL,
      dac_core_pkg::REG_SYNC,
      dac_core_pkg::REG_STATUS: wr_hit = up_req.wreq;
      default:                  wr_hit = 1'b0;
    endcase
  end

  always_comb begin
    rd_hit  = up_req.rreq;
    rd_data = '0;
    case (up_req.raddr)
      dac_core_pkg::REG_VERSION: rd_data = dac_core_pkg::CORE_VERSION;
      dac_core_pkg::REG_SCRATCH: rd_data = up_scratch;
      dac_core_pkg::REG_CTRL:    rd_data[1:0] = {up_datafmt, up_resetn};
      // sync is write only
      dac_core_pkg::REG_SYNC:    rd_data = '0;
      dac_core_pkg::REG_STATUS:  rd_data[1:0] = up_status;
      default:                   rd_hit = 1'b0;
    endcase
  end

  assign status_clr = (up_req.wreq && up_req.waddr == dac_core_pkg::REG_STATUS) ?
                      up_req.wdata[1:0] : 2'b00;

  // ****************************************
  // registers
  // ****************************************

  always_ff @(posedge dac_clk) begin
    if (!up_rstn) begin
      up_rsp     <= '0;
      up_scratch <= '0;
      up_resetn  <= 1'b0;
      up_datafmt <= 1'b0;
      up_status  <= 2'b00;
    end else begin
      up_rsp.wack  <= wr_hit;
      up_rsp.rack  <= rd_hit;
      up_rsp.rdata <= rd_hit ? rd_data : '0;
      if (up_req.wreq && up_req.waddr == dac_core_pkg::REG_SCRATCH) begin
        up_scratch <= up_req.wdata;
      end
      if (up_req.wreq && up_req.waddr == dac_core_pkg::REG_CTRL) begin
        up_resetn  <= up_req.wdata[0];
        up_datafmt <= up_req.wdata[1];
      end
      // a new event wins over a clear in the same cycle
      up_status <= (up_status & ~status_clr) | {dac_dovf, dac_dunf};
    end
  end

  // levels go through one more stage so they line up with the channel config copies
  always_ff @(posedge dac_clk) begin
    if (!up_rstn) begin
      dac_rst     <= 1'b1;
      dac_datafmt <= 1'b0;
      dac_sync    <= 1'b0;
    end else begin
      dac_rst     <= ~up_resetn;
      dac_datafmt <= up_datafmt;
      dac_sync    <= up_req.wreq && (up_req.waddr == dac_core_pkg::REG_SYNC) &&
                     up_req.wdata[0];
    end
  end

endmodule

`default_nettype wire

// File: up_bus_merge.sv
// merges register responses; assumes one access in flight and acks each two cycles after it
`timescale 1ns/1ps
`default_nettype none

module up_bus_merge #(
  parameter int NUM_SOURCES = 3
) (
  input  wire                   dac_clk,
  input  wire                   up_rstn,
  input  wire dac_core_pkg::up_req_t up_req,
  input  wire dac_core_pkg::up_rsp_t [NUM_SOURCES-1:0] rsp_in,
  output dac_core_pkg::up_rsp_t      up_rsp
);

  dac_core_pkg::up_rsp_t rsp_or;
  logic                  wreq_d;
  logic                  rreq_d;
  logic                  wr_miss;
  logic                  rd_miss;

  // idle blocks return zeros so a plain OR is enough
  always_comb begin
    rsp_or = '0;
    for (int i = 0; i < NUM_SOURCES; i++) begin
      rsp_or = rsp_or | rsp_in[i];
    end
  end

  // nobody claimed the address
  assign wr_miss = wreq_d && !rsp_or.wack;
  assign rd_miss = rreq_d && !rsp_or.rack;

  always_ff @(posedge dac_clk) begin
    if (!up_rstn) begin
      wreq_d <= 1'b0;
      rreq_d <= 1'b0;
      up_rsp <= '0;
    end else begin
      wreq_d       <= up_req.wreq;
      rreq_d       <= up_req.rreq;
      up_rsp.wack  <= rsp_or.wack | wr_miss;
      up_rsp.rack  <= rsp_or.rack | rd_miss;
      // an unclaimed read carries zero data
      up_rsp.rdata <= rsp_or.rdata;
    end
  end

endmodule

`default_nettype wire

// File: dac_core.sv
// transmit core top; register bus and datapath share dac_clk and there is no JESD link or DDS here
`timescale 1ns/1ps
`default_nettype none

module dac_core (
  input  wire                   dac_clk,
  input  wire                   up_rstn,
  input  wire dac_core_pkg::up_req_t up_req,
  output wire dac_core_pkg::up_rsp_t up_rsp,
  input  wire dac_core_pkg::dac_frame_t [dac_core_pkg::NUM_CHANNELS-1:0] dma_data,
  input  wire                   dac_dunf,
  input  wire                   dac_dovf,
  output wire dac_core_pkg::dac_frame_t [dac_core_pkg::NUM_CHANNELS-1:0] dac_data,
  output wire [dac_core_pkg::NUM_CHANNELS-1:0] dac_valid,
  output wire [dac_core_pkg::NUM_CHANNELS-1:0] dac_enable,
  output wire                   dac_rst
);

  // channels first and the common block in the top slot
  dac_core_pkg::up_rsp_t [dac_core_pkg::NUM_CHANNELS:0] rsp_all;
  logic                                                 dac_sync_s;
  logic                                                 dac_datafmt_s;

  // ****************************************
  // channels
  // ****************************************

  genvar c;
  generate
    for (c = 0; c < dac_core_pkg::NUM_CHANNELS; c++) begin : g_channel
      dac_channel #(
        .CHANNEL_ID (c)
      ) i_channel (
        .dac_clk     (dac_clk),
        .up_rstn     (up_rstn),
        .up_req      (up_req),
        .up_rsp      (rsp_all[c]),
        .dma_data    (dma_data[c]),
        .dac_rst     (dac_rst),
        .dac_sync    (dac_sync_s),
        .dac_datafmt (dac_datafmt_s),
        .dac_data    (dac_data[c]),
        .dac_valid   (dac_valid[c]),
        .dac_enable  (dac_enable[c])
      );
    end
  endgenerate

  // ****************************************
  // common registers and response merge
  // ****************************************

  dac_common_regs i_common_regs (
    .dac_clk     (dac_clk),
    .up_rstn     (up_rstn),
    .up_req      (up_req),
    .up_rsp      (rsp_all[dac_core_pkg::NUM_CHANNELS]),
    .dac_dunf    (dac_dunf),
    .dac_dovf    (dac_dovf),
    .dac_rst     (dac_rst),
    .dac_sync    (dac_sync_s),
    .dac_datafmt (dac_datafmt_s)
  );

  up_bus_merge #(
    .NUM_SOURCES (dac_core_pkg::NUM_CHANNELS + 1)
  ) i_bus_merge (
    .dac_clk (dac_clk),
    .up_rstn (up_rstn),
    .up_req  (up_req),
    .rsp_in  (rsp_all),
    .up_rsp  (up_rsp)
  );

endmodule

`default_nettype wire

// File: tb_dac_model.svh
// register shadow and expected frames for dac_core; included inside the testbench module body
`ifndef TB_DAC_MODEL_SVH
`define TB_DAC_MODEL_SVH

// shadow of the register map
logic [dac_core_pkg::DATA_W-1:0]   sh_scratch;
logic                              sh_resetn;
logic                              sh_datafmt;
logic [1:0]                        sh_status;
logic [1:0]                        sh_src     [dac_core_pkg::NUM_CHANNELS];
logic [dac_core_pkg::SAMPLE_W-1:0] sh_pattern [dac_core_pkg::NUM_CHANNELS];
logic                              sh_enable  [dac_core_pkg::NUM_CHANNELS];

function automatic void shadow_reset();
  sh_scratch = '0;
  sh_resetn  = 1'b0;
  sh_datafmt = 1'b0;
  sh_status  = 2'b00;
  for (int c = 0; c < dac_core_pkg::NUM_CHANNELS; c++) begin
    sh_src[c]     = 2'd0;
    sh_pattern[c] = '0;
    sh_enable[c]  = 1'b0;
  end
endfunction

function automatic logic [dac_core_pkg::ADDR_W-1:0] chan_addr(input int c,
    input logic [dac_core_pkg::ADDR_W-1:0] off);
  return dac_core_pkg::CHAN_BASE + dac_core_pkg::CHAN_STRIDE * 14'(c) + off;
endfunction

// true only for a mapped channel register, which it splits into channel and offset
function automatic bit chan_slot(input logic [dac_core_pkg::ADDR_W-1:0] addr,
    output int c, output int r);
  int off;
  off = int'(addr) - int'(dac_core_pkg::CHAN_BASE);
  c = off / int'(dac_core_pkg::CHAN_STRIDE);
  r = off % int'(dac_core_pkg::CHAN_STRIDE);
  return (off >= 0) && (c < dac_core_pkg::NUM_CHANNELS) &&
         (r < int'(dac_core_pkg::CHAN_NUM_REGS));
endfunction

function automatic void shadow_write(input logic [dac_core_pkg::ADDR_W-1:0] addr,
    input logic [dac_core_pkg::DATA_W-1:0] data);
  int c;
  int r;
  if (addr == dac_core_pkg::REG_SCRATCH) sh_scratch = data;
  if (addr == dac_core_pkg::REG_CTRL) begin
    sh_resetn  = data[0];
    sh_datafmt = data[1];
  end
  // write one to clear
  if (addr == dac_core_pkg::REG_STATUS) sh_status = sh_status & ~data[1:0];
  if (chan_slot(addr, c, r)) begin
    if (r == 0) sh_src[c] = data[1:0];
    if (r == 1) sh_pattern[c] = data[dac_core_pkg::SAMPLE_W-1:0];
    if (r == 2) sh_enable[c] = data[0];
  end
endfunction

function automatic logic [dac_core_pkg::DATA_W-1:0] expected_read(
    input logic [dac_core_pkg::ADDR_W-1:0] addr);
  int c;
  int r;
  if (addr == dac_core_pkg::REG_VERSION) return dac_core_pkg::CORE_VERSION;
  if (addr == dac_core_pkg::REG_SCRATCH) return sh_scratch;
  if (addr == dac_core_pkg::REG_CTRL) return {30'h0, sh_datafmt, sh_resetn};
  if (addr == dac_core_pkg::REG_STATUS) return {30'h0, sh_status};
  if (chan_slot(addr, c, r)) begin
    if (r == 0) return {30'h0, sh_src[c]};
    if (r == 1) return {16'h0, sh_pattern[c]};
    return {31'h0, sh_enable[c]};
  end
  // sync and unmapped addresses read as zero
  return '0;
endfunction

// output rule for one channel with ramp as the base of the frame
function automatic dac_core_pkg::dac_frame_t expected_frame(input int c,
    input dac_core_pkg::dac_frame_t din, input logic [dac_core_pkg::SAMPLE_W-1:0] ramp);
  dac_core_pkg::dac_frame_t f;
  logic [dac_core_pkg::SAMPLE_W-1:0] s;
  f = '0;
  if (sh_resetn && sh_enable[c]) begin
    for (int k = 0; k < dac_core_pkg::SAMPLES_PER_BEAT; k++) begin
      case (sh_src[c])
        2'd0:    s = din.sample[k];
        2'd1:    s = sh_pattern[c];
        2'd2:    s = ramp + 16'(k);
        default: s = '0;
      endcase
      if (sh_datafmt) s[dac_core_pkg::SAMPLE_W-1] = ~s[dac_core_pkg::SAMPLE_W-1];
      f.sample[k] = s;
    end
  end
  return f;
endfunction

// packed as {dac_rst, dac_enable, dac_valid}
function automatic logic [2*dac_core_pkg::NUM_CHANNELS:0] expected_flags();
  logic [dac_core_pkg::NUM_CHANNELS-1:0] en;
  for (int c = 0; c < dac_core_pkg::NUM_CHANNELS; c++) en[c] = sh_enable[c];
  return {~sh_resetn, en, en & {dac_core_pkg::NUM_CHANNELS{sh_resetn}}};
endfunction

`endif

// File: tb_dac_core.sv
// testbench for dac_core; inputs change on the falling edge and the run stops at the first mismatch
`timescale 1ns/1ps
`default_nettype none

module tb_dac_core;

  localparam int NCH           = dac_core_pkg::NUM_CHANNELS;
  localparam int REG_OPS       = 60;
  localparam int DMA_CYCLES    = 200;
  localparam int CONST_CYCLES  = 16;
  localparam int RAMP_CYCLES   = 20;
  localparam int STATUS_CYCLES = 24;
  // about 3 cycles per bus access and up to 40 accesses outside the random loop
  localparam int TEST_CYCLES   = 6 + 3 * (REG_OPS + 40) + DMA_CYCLES + 4 * CONST_CYCLES +
                                 RAMP_CYCLES + STATUS_CYCLES;
  localparam int TIMEOUT_NS    = 2 * TEST_CYCLES * 100;

  logic                               dac_clk;
  logic                               up_rstn;
  dac_core_pkg::up_req_t              up_req;
  dac_core_pkg::up_rsp_t              up_rsp;
  dac_core_pkg::dac_frame_t [NCH-1:0] dma_data;
  dac_core_pkg::dac_frame_t [NCH-1:0] dac_data;
  logic [NCH-1:0]                     dac_valid;
  logic [NCH-1:0]                     dac_enable;
  logic                               dac_dunf;
  logic                               dac_dovf;
  logic                               dac_rst;
  logic [31:0]                        rng_state;

  `include "tb_dac_model.svh"

  dac_core dac_core_i (
    .dac_clk    (dac_clk),
    .up_rstn    (up_rstn),
    .up_req     (up_req),
    .up_rsp     (up_rsp),
    .dma_data   (dma_data),
    .dac_dunf   (dac_dunf),
    .dac_dovf   (dac_dovf),
    .dac_data   (dac_data),
    .dac_valid  (dac_valid),
    .dac_enable (dac_enable),
    .dac_rst    (dac_rst)
  );

  always #50 dac_clk = ~dac_clk;

  // ****************************************
  // helpers
  // ****************************************

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_rsp(input string name, input logic [dac_core_pkg::DATA_W-1:0] got,
                           input logic [dac_core_pkg::DATA_W-1:0] exp);
    if (got !== exp)
      fail_run($sformatf("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_frame(input string name, input dac_core_pkg::dac_frame_t got,
                             input dac_core_pkg::dac_frame_t exp);
    if (got !== exp)
      fail_run($sformatf("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_flags(input logic [2*NCH:0] got, input logic [2*NCH:0] exp);
    if (got !== exp)
      fail_run($sformatf("mismatch at %0d ns: {dac_rst,dac_enable,dac_valid} got %b expected %b",
                         $time, got, exp));
  endtask

  // starts and ends just after a falling edge; the ack must come 2 cycles after the request
  task automatic bus_access(input logic is_write, input logic [dac_core_pkg::ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int   n;
    logic ack;
    n   = 0;
    ack = 1'b0;
    up_req.wreq  = is_write;
    up_req.waddr = addr;
    up_req.wdata = wdata;
    up_req.rreq  = !is_write;
    up_req.raddr = addr;
    while (!ack) begin
      @(negedge dac_clk);
      n++;
      up_req.wreq = 1'b0;
      up_req.rreq = 1'b0;
      ack = is_write ? up_rsp.wack : up_rsp.rack;
      if (!ack) begin
        check_rsp("up_rsp.rdata without rack", up_rsp.rdata, '0);
        if (n >= 4) fail_run($sformatf("no ack for the access to 0x%h within 4 cycles", addr));
      end
    end
    if (n != 2) fail_run($sformatf("ack for 0x%h came after %0d cycles instead of 2", addr, n));
    rdata = up_rsp.rdata;
  endtask

  task automatic bus_write(input logic [dac_core_pkg::ADDR_W-1:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    bus_access(1'b1, addr, data, rd);
    shadow_write(addr, data);
  endtask

  task automatic bus_read_check(input logic [dac_core_pkg::ADDR_W-1:0] addr);
    logic [31:0] rd;
    bus_access(1'b0, addr, '0, rd);
    check_rsp($sformatf("up_rsp.rdata at 0x%h", addr), rd, expected_read(addr));
  endtask

  // new random DMA frame every cycle and its output checked one cycle later
  task automatic stream_check(input int cycles);
    dac_core_pkg::dac_frame_t [NCH-1:0] frames;
    for (int i = 0; i < cycles; i++) begin
      for (int c = 0; c < NCH; c++) frames[c] = {next_rand(), next_rand()};
      dma_data = frames;
      @(negedge dac_clk);
      for (int c = 0; c < NCH; c++)
        check_frame($sformatf("dac_data[%0d]", c), dac_data[c], expected_frame(c, frames[c], '0));
      check_flags({dac_rst, dac_enable, dac_valid}, expected_flags());
    end
  endtask

  // ****************************************
  // test sequence
  // ****************************************

  initial begin
    logic [31:0]                     r;
    logic [dac_core_pkg::ADDR_W-1:0] addr;
    logic [15:0]                     base;
    int                              c;
    rng_state = 32'd13709;
    dac_clk   = 1'b0;
    up_rstn   = 1'b0;
    up_req    = '0;
    dma_data  = '0;
    dac_dunf  = 1'b0;
    dac_dovf  = 1'b0;
    shadow_reset();
    repeat (5) @(posedge dac_clk);
    @(negedge dac_clk);
    up_rstn = 1'b1;
    @(negedge dac_clk);

    // reset state
    check_flags({dac_rst, dac_enable, dac_valid}, expected_flags());
    for (int k = 0; k < NCH; k++) check_frame($sformatf("dac_data[%0d]", k), dac_data[k], '0);
    bus_read_check(dac_core_pkg::REG_VERSION);

    // random register traffic to mapped and unmapped addresses
    for (int i = 0; i < REG_OPS; i++) begin
      r = next_rand();
      c = int'(r[8]);
      case (r[2:0])
        3'd0, 3'd1: addr = dac_core_pkg::REG_SCRATCH;
        3'd2:       addr = chan_addr(c, dac_core_pkg::CHAN_SRC);
        3'd3:       addr = chan_addr(c, dac_core_pkg::CHAN_PATTERN);
        3'd4:       addr = chan_addr(c, dac_core_pkg::CHAN_ENABLE);
        3'd5:       addr = chan_addr(c, 14'd3 + 14'(r[11:9]));
        3'd6:       addr = 14'h0005 + 14'(r[7:3]);
        default:    addr = {2'b11, r[19:8]};
      endcase
      if (r[31]) bus_write(addr, next_rand());
      else bus_read_check(addr);
    end
    bus_write(dac_core_pkg::REG_SYNC, 32'h1);
    bus_read_check(dac_core_pkg::REG_SYNC);
    bus_read_check(dac_core_pkg::REG_CTRL);

    // DMA source with offset binary switched on halfway
    bus_write(dac_core_pkg::REG_CTRL, 32'h1);
    for (int k = 0; k < NCH; k++) begin
      bus_write(chan_addr(k, dac_core_pkg::CHAN_SRC), 32'(dac_core_pkg::SRC_DMA));
      bus_write(chan_addr(k, dac_core_pkg::CHAN_ENABLE), 32'h1);
    end
    stream_check(DMA_CYCLES / 2);
    bus_write(dac_core_pkg::REG_CTRL, 32'h3);
    stream_check(DMA_CYCLES / 2);

    // pattern and zero sources, then disable, then converter reset
    r = next_rand();
    bus_write(chan_addr(0, dac_core_pkg::CHAN_PATTERN), {16'h0, r[31:16]});
    bus_write(chan_addr(0, dac_core_pkg::CHAN_SRC), 32'(dac_core_pkg::SRC_PATTERN));
    bus_write(chan_addr(1, dac_core_pkg::CHAN_SRC), 32'(dac_core_pkg::SRC_ZERO));
    stream_check(CONST_CYCLES);
    bus_write(dac_core_pkg::REG_CTRL, 32'h1);
    stream_check(CONST_CYCLES);
    bus_write(chan_addr(1, dac_core_pkg::CHAN_ENABLE), 32'h0);
    stream_check(CONST_CYCLES);
    bus_write(dac_core_pkg::REG_CTRL, 32'h0);
    stream_check(CONST_CYCLES);

    // ramp restarts at 0 in the cycle of the sync ack
    bus_write(dac_core_pkg::REG_CTRL, 32'h1);
    for (int k = 0; k < NCH; k++) begin
      bus_write(chan_addr(k, dac_core_pkg::CHAN_SRC), 32'(dac_core_pkg::SRC_RAMP));
      bus_write(chan_addr(k, dac_core_pkg::CHAN_ENABLE), 32'h1);
    end
    bus_write(dac_core_pkg::REG_SYNC, 32'h1);
    base = 16'h0000;
    for (int i = 0; i < RAMP_CYCLES; i++) begin
      for (int k = 0; k < NCH; k++)
        check_frame($sformatf("dac_data[%0d]", k), dac_data[k],
                    expected_frame(k, dma_data[k], base));
      base = base + 16'd4;
      @(negedge dac_clk);
    end

    // sticky status and write one to clear
    for (int i = 0; i < STATUS_CYCLES; i++) begin
      r = next_rand();
      dac_dunf  = r[0];
      dac_dovf  = r[2];
      sh_status = sh_status | {dac_dovf, dac_dunf};
      @(negedge dac_clk);
    end
    dac_dunf = 1'b0;
    dac_dovf = 1'b0;
    bus_read_check(dac_core_pkg::REG_STATUS);
    bus_write(dac_core_pkg::REG_STATUS, 32'h0);
    bus_read_check(dac_core_pkg::REG_STATUS);
    bus_write(dac_core_pkg::REG_STATUS, 32'h1);
    bus_read_check(dac_core_pkg::REG_STATUS);
    bus_write(dac_core_pkg::REG_STATUS, 32'h2);
    bus_read_check(dac_core_pkg::REG_STATUS);

    $display("TB PASSED");
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    fail_run($sformatf("watchdog expired after %0d ns, the test did not finish", TIMEOUT_NS));
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
dac_core_pkg.sv
dac_channel.sv
dac_common_regs.sv
up_bus_merge.sv
dac_core.sv
tb_dac_core.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it; exit status is the simulation result
set -e
cd "$(dirname "$0")"
verilator --binary -f sim.f --top-module tb_dac_core -o tb_dac_core
./obj_dir/tb_dac_core
